// ==== logic/ooo_pkg.sv ====
// shared sizes and types for the integer out-of-order back end
// sizes are fixed here, no module takes a size parameter
// free queue depth assumes at most ROB_SIZE destinations in flight
package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int AREG_COUNT = 32;
    localparam int PREG_COUNT = 64;
    localparam int ROB_SIZE   = 16;
    localparam int RS_SIZE    = 4;
    localparam int FREE_COUNT = PREG_COUNT - AREG_COUNT;  // regs 32..63 free at reset

    typedef logic [XLEN-1:0]                 word_t;
    typedef logic [$clog2(AREG_COUNT)-1:0]   areg_t;
    typedef logic [$clog2(PREG_COUNT)-1:0]   preg_t;
    typedef logic [$clog2(ROB_SIZE)-1:0]     rob_idx_t;
    typedef logic [$clog2(ROB_SIZE):0]       rob_cnt_t;   // 0..ROB_SIZE
    typedef logic [$clog2(RS_SIZE)-1:0]      rs_idx_t;
    typedef logic [$clog2(FREE_COUNT)-1:0]   free_idx_t;
    typedef logic [$clog2(FREE_COUNT):0]     free_cnt_t;  // 0..FREE_COUNT

    // x0, never renamed, backed by physical reg 0
    localparam areg_t ZERO_REG = '0;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_func_t;

endpackage

// ==== logic/cdb_if.sv ====
// common data bus, one result per cycle from the single ALU
// valid is a one cycle pulse, payload only meaningful while it is high
`timescale 1ns/1ps

interface cdb_if import ooo_pkg::*; ();

    logic     valid;
    word_t    value;
    preg_t    dest_preg;   // tag for wakeup and prf write
    rob_idx_t rob_idx;     // slot to mark done

    // ALU drives the bus
    modport source (output valid, value, dest_preg, rob_idx);

    // station, prf and rob listen
    modport sink (input valid, value, dest_preg, rob_idx);

endinterface

// ==== logic/rename_map.sv ====
// speculative map (rat) and committed map (rrat)
// x0 always reads physical reg 0 and is never written in either map
// no recovery path, the speculative map is never restored
`timescale 1ns/1ps

module rename_map import ooo_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  rename_en,
    input  areg_t opa_areg,
    input  areg_t opb_areg,
    input  areg_t dest_areg,
    input  preg_t new_preg,
    input  logic  commit_en,
    input  areg_t commit_areg,
    input  preg_t commit_preg,
    output preg_t opa_preg,
    output preg_t opb_preg,
    output logic  free_preg_en,
    output preg_t free_preg
);

    preg_t spec_map [AREG_COUNT];
    preg_t arch_map [AREG_COUNT];

    // lookup sees the map before this cycle's dest write
    assign opa_preg = (opa_areg == ZERO_REG) ? '0 : spec_map[opa_areg];
    assign opb_preg = (opb_areg == ZERO_REG) ? '0 : spec_map[opb_areg];

    // old committed mapping goes back to the free queue
    assign free_preg_en = commit_en && (commit_areg != ZERO_REG);
    assign free_preg    = arch_map[commit_areg];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < AREG_COUNT; i++) begin
                spec_map[i] <= preg_t'(i);   // identity map at start
                arch_map[i] <= preg_t'(i);
            end
        end else begin
            if (rename_en && (dest_areg != ZERO_REG))
                spec_map[dest_areg] <= new_preg;
            if (commit_en && (commit_areg != ZERO_REG))
                arch_map[commit_areg] <= commit_preg;
        end
    end

    // a commit never frees the register it is committing
    assert property (@(posedge clock) disable iff (reset)
        free_preg_en |-> (free_preg != commit_preg));

endmodule

// ==== logic/phys_reg_file.sv ====
// physical register values, ready bits and the free register queue
// reg 0 holds zero, is always ready and ignores cdb writes
// free queue holds FREE_COUNT entries and is never expected to empty
// operand reads forward a cdb result landing in the same cycle
`timescale 1ns/1ps

module phys_reg_file import ooo_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  alloc_en,
    input  preg_t opa_preg,
    input  preg_t opb_preg,
    input  logic  free_en,
    input  preg_t free_preg,
    input  preg_t commit_preg,
    cdb_if.sink   cdb,
    output preg_t alloc_preg,
    output word_t opa_value,
    output word_t opb_value,
    output logic  opa_ready,
    output logic  opb_ready,
    output word_t commit_value
);

    word_t                 values [PREG_COUNT];
    logic [PREG_COUNT-1:0] ready;
    preg_t                 free_q [FREE_COUNT];
    free_idx_t             fq_head;
    free_idx_t             fq_tail;
    free_cnt_t             fq_count;
    logic                  cdb_write;
    logic                  opa_fwd;
    logic                  opb_fwd;

    assign cdb_write = cdb.valid && (cdb.dest_preg != '0);  // x0 results dropped
    assign opa_fwd   = cdb_write && (cdb.dest_preg == opa_preg);
    assign opb_fwd   = cdb_write && (cdb.dest_preg == opb_preg);

    assign opa_value = opa_fwd ? cdb.value : values[opa_preg];
    assign opb_value = opb_fwd ? cdb.value : values[opb_preg];
    assign opa_ready = opa_fwd || ready[opa_preg];
    assign opb_ready = opb_fwd || ready[opb_preg];

    assign alloc_preg   = free_q[fq_head];
    assign commit_value = values[commit_preg];  // read while commit_valid

    ////////////////////////////////////////
    // values and ready bits
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PREG_COUNT; i++)
                values[i] <= '0;                 // architectural state starts at zero
            ready <= '1;
        end else begin
            if (alloc_en)
                ready[alloc_preg] <= 1'b0;       // pending until its result lands
            if (cdb_write) begin
                values[cdb.dest_preg] <= cdb.value;
                ready[cdb.dest_preg]  <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // free queue, pop at head, push at tail
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_COUNT; i++)
                free_q[i] <= preg_t'(AREG_COUNT + i);
            fq_head  <= '0;
            fq_tail  <= '0;
            fq_count <= free_cnt_t'(FREE_COUNT);
        end else begin
            if (free_en) begin
                free_q[fq_tail] <= free_preg;
                fq_tail         <= fq_tail + 1'b1;
            end
            if (alloc_en)
                fq_head <= fq_head + 1'b1;
            fq_count <= fq_count + free_cnt_t'(free_en) - free_cnt_t'(alloc_en);
        end
    end

    // rob depth must keep the queue from running dry
    assert property (@(posedge clock) disable iff (reset)
        alloc_en |-> (fq_count != '0));

endmodule

// ==== logic/reorder_buffer.sv ====
// circular reorder buffer, one dispatch and one commit per cycle
// commit outputs are registered, one cycle after the head is seen done
// halt takes a slot only, done at dispatch, maps to x0 and frees nothing
// dispatch_ready also folds in the station full level for non-halt ops
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  logic     dispatch_halt,
    input  logic     rs_full,
    input  areg_t    dest_areg,
    input  preg_t    dest_preg,
    cdb_if.sink      cdb,
    output logic     dispatch_ready,
    output logic     accept,
    output rob_idx_t tail,
    output logic     commit_valid,
    output logic     commit_halt,
    output areg_t    commit_areg,
    output preg_t    commit_preg
);

    rob_idx_t            head;
    rob_cnt_t            count;
    logic [ROB_SIZE-1:0] done;
    areg_t               areg_q [ROB_SIZE];
    preg_t               preg_q [ROB_SIZE];
    logic                halt_q [ROB_SIZE];
    logic                full;
    logic                take;
    logic                retire;

    assign full           = (count == rob_cnt_t'(ROB_SIZE));
    assign dispatch_ready = !full && (dispatch_halt || !rs_full);
    assign take           = dispatch_valid && dispatch_ready;
    assign accept         = take && !dispatch_halt;   // rename + station write
    assign retire         = (count != '0) && done[head];

    // entry payload and commit payload
    always_ff @(posedge clock) begin
        if (take) begin
            areg_q[tail] <= dispatch_halt ? ZERO_REG : dest_areg;
            preg_q[tail] <= dispatch_halt ? '0 : dest_preg;
            halt_q[tail] <= dispatch_halt;
        end
        if (retire) begin
            commit_areg <= areg_q[head];
            commit_preg <= preg_q[head];
        end
    end

    ////////////////////////////////////////
    // pointers, done bits, commit strobes
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
            commit_halt  <= 1'b0;
        end else begin
            commit_valid <= retire;
            commit_halt  <= retire && halt_q[head];
            if (cdb.valid)
                done[cdb.rob_idx] <= 1'b1;        // result written back
            if (retire) begin
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (take) begin
                done[tail] <= dispatch_halt;      // halt needs no execute
                tail       <= tail + 1'b1;
            end
            count <= count + rob_cnt_t'(take) - rob_cnt_t'(retire);
        end
    end

    // dispatch only into a free, cleared slot
    assert property (@(posedge clock) disable iff (reset)
        take |-> !full && !done[tail]);

    // alu results only land on live slots still waiting
    assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (count != '0) && !done[cdb.rob_idx]);

endmodule

// ==== logic/alu_station.sv ====
// alu reservation station, RS_SIZE entries
// writes into the lowest free slot, issues the lowest ready slot
// operand values at dispatch already include same cycle cdb forwarding
// an entry woken by the cdb can issue from the next cycle on
`timescale 1ns/1ps

module alu_station import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch_en,
    input  alu_func_t func,
    input  preg_t     opa_preg,
    input  preg_t     opb_preg,
    input  preg_t     dest_preg,
    input  word_t     opa_value,
    input  word_t     opb_value,
    input  logic      opa_ready,
    input  logic      opb_ready,
    input  logic      opb_is_imm,
    input  word_t     imm,
    input  rob_idx_t  rob_idx,
    cdb_if.sink       cdb,
    output logic      rs_full,
    output logic      issue_valid,
    output alu_func_t issue_func,
    output word_t     issue_a,
    output word_t     issue_b,
    output preg_t     issue_preg,
    output rob_idx_t  issue_rob_idx
);

    logic [RS_SIZE-1:0] valid;
    logic [RS_SIZE-1:0] a_rdy;
    logic [RS_SIZE-1:0] b_rdy;
    logic [RS_SIZE-1:0] ready_vec;
    alu_func_t          func_q [RS_SIZE];
    word_t              a_val  [RS_SIZE];
    word_t              b_val  [RS_SIZE];
    preg_t              a_tag  [RS_SIZE];
    preg_t              b_tag  [RS_SIZE];
    preg_t              dest_q [RS_SIZE];
    rob_idx_t           rob_q  [RS_SIZE];
    rs_idx_t            free_idx;
    rs_idx_t            issue_idx;

    assign rs_full     = &valid;
    assign ready_vec   = valid & a_rdy & b_rdy;
    assign issue_valid = |ready_vec;

    // downward scan so the lowest index wins
    always_comb begin
        free_idx  = '0;
        issue_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!valid[i])
                free_idx = rs_idx_t'(i);
            if (ready_vec[i])
                issue_idx = rs_idx_t'(i);
        end
    end

    assign issue_func    = func_q[issue_idx];
    assign issue_a       = a_val[issue_idx];
    assign issue_b       = b_val[issue_idx];
    assign issue_preg    = dest_q[issue_idx];
    assign issue_rob_idx = rob_q[issue_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (issue_valid)
                valid[issue_idx] <= 1'b0;   // freed on issue
            if (dispatch_en)
                valid[free_idx] <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // wakeup and entry write
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (cdb.valid && valid[i] && !a_rdy[i] && (a_tag[i] == cdb.dest_preg)) begin
                a_val[i] <= cdb.value;
                a_rdy[i] <= 1'b1;
            end
            if (cdb.valid && valid[i] && !b_rdy[i] && (b_tag[i] == cdb.dest_preg)) begin
                b_val[i] <= cdb.value;
                b_rdy[i] <= 1'b1;
            end
        end
        if (dispatch_en) begin
            func_q[free_idx] <= func;
            a_tag[free_idx]  <= opa_preg;
            b_tag[free_idx]  <= opb_preg;
            a_val[free_idx]  <= opa_value;
            a_rdy[free_idx]  <= opa_ready;
            b_val[free_idx]  <= opb_is_imm ? imm : opb_value;  // imm replaces rs2
            b_rdy[free_idx]  <= opb_is_imm || opb_ready;
            dest_q[free_idx] <= dest_preg;
            rob_q[free_idx]  <= rob_idx;
        end
    end

    // rob must hold back non-halt dispatch while the station is full
    assert property (@(posedge clock) disable iff (reset)
        dispatch_en |-> !rs_full);

endmodule

// ==== logic/alu_unit.sv ====
// single cycle integer alu, output register is the cdb
// shifts use the low 5 bits of operand b, slt/sltu give 0 or 1
`timescale 1ns/1ps

module alu_unit import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      issue_valid,
    input  alu_func_t issue_func,
    input  word_t     issue_a,
    input  word_t     issue_b,
    input  preg_t     issue_preg,
    input  rob_idx_t  issue_rob_idx,
    cdb_if.source     cdb
);

    word_t                     result;
    logic [$clog2(XLEN)-1:0]   shamt;

    assign shamt = issue_b[$clog2(XLEN)-1:0];

    always_comb begin
        case (issue_func)
            ALU_ADD:  result = issue_a + issue_b;
            ALU_SUB:  result = issue_a - issue_b;
            ALU_AND:  result = issue_a & issue_b;
            ALU_OR:   result = issue_a | issue_b;
            ALU_XOR:  result = issue_a ^ issue_b;
            ALU_SLL:  result = issue_a << shamt;
            ALU_SRL:  result = issue_a >> shamt;
            ALU_SRA:  result = word_t'($signed(issue_a) >>> shamt);
            ALU_SLT:  result = word_t'($signed(issue_a) < $signed(issue_b));
            ALU_SLTU: result = word_t'(issue_a < issue_b);
            default:  result = '0;    // unused encodings
        endcase
    end

    // one pulse per issued op
    always_ff @(posedge clock) begin
        if (reset)
            cdb.valid <= 1'b0;
        else
            cdb.valid <= issue_valid;
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            cdb.value     <= result;
            cdb.dest_preg <= issue_preg;
            cdb.rob_idx   <= issue_rob_idx;
        end
    end

endmodule

// ==== logic/ooo_core.sv ====
// rename, issue and commit back end, integer alu path only
// one dispatch per cycle, taken when dispatch_valid and dispatch_ready
// sender holds the instruction steady until it is taken
// commit_value is valid only while commit_valid is high
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  alu_func_t dispatch_func,
    input  areg_t     dispatch_dest_areg,
    input  areg_t     dispatch_opa_areg,
    input  areg_t     dispatch_opb_areg,
    input  logic      dispatch_opb_is_imm,
    input  word_t     dispatch_imm,
    input  logic      dispatch_halt,
    output logic      dispatch_ready,
    output logic      commit_valid,
    output areg_t     commit_areg,
    output word_t     commit_value,
    output logic      commit_halt
);

    preg_t    opa_preg;      // map -> prf
    preg_t    opb_preg;
    logic     free_preg_en;  // map -> prf
    preg_t    free_preg;
    preg_t    alloc_preg;    // prf -> map
    logic     alloc_en;
    preg_t    dest_preg;     // -> rob, station
    word_t    opa_value;     // prf -> station
    word_t    opb_value;
    logic     opa_ready;
    logic     opb_ready;
    logic     accept;        // rob -> map, station
    rob_idx_t rob_tail;
    logic     rs_full;
    preg_t    commit_preg;   // rob -> map, prf
    logic     issue_valid;   // station -> alu
    alu_func_t issue_func;
    word_t    issue_a;
    word_t    issue_b;
    preg_t    issue_preg;
    rob_idx_t issue_rob_idx;

    cdb_if cdb_bus ();

    // x0 destinations take no register and write back to preg 0
    assign alloc_en  = accept && (dispatch_dest_areg != ZERO_REG);
    assign dest_preg = alloc_en ? alloc_preg : '0;

    ////////////////////////////////////////
    // rename and register file
    ////////////////////////////////////////
    rename_map rename_map_i (
        .clock(clock), .reset(reset),
        .rename_en(accept),
        .opa_areg(dispatch_opa_areg), .opb_areg(dispatch_opb_areg),
        .dest_areg(dispatch_dest_areg), .new_preg(alloc_preg),
        .commit_en(commit_valid), .commit_areg(commit_areg), .commit_preg(commit_preg),
        .opa_preg(opa_preg), .opb_preg(opb_preg),
        .free_preg_en(free_preg_en), .free_preg(free_preg)
    );

    phys_reg_file phys_reg_file_i (
        .clock(clock), .reset(reset),
        .alloc_en(alloc_en), .opa_preg(opa_preg), .opb_preg(opb_preg),
        .free_en(free_preg_en), .free_preg(free_preg), .commit_preg(commit_preg),
        .cdb(cdb_bus),
        .alloc_preg(alloc_preg), .opa_value(opa_value), .opb_value(opb_value),
        .opa_ready(opa_ready), .opb_ready(opb_ready), .commit_value(commit_value)
    );

    ////////////////////////////////////////
    // rob, station, alu
    ////////////////////////////////////////
    reorder_buffer reorder_buffer_i (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_halt(dispatch_halt), .rs_full(rs_full),
        .dest_areg(dispatch_dest_areg), .dest_preg(dest_preg), .cdb(cdb_bus),
        .dispatch_ready(dispatch_ready), .accept(accept), .tail(rob_tail),
        .commit_valid(commit_valid), .commit_halt(commit_halt),
        .commit_areg(commit_areg), .commit_preg(commit_preg)
    );

    alu_station alu_station_i (
        .clock(clock), .reset(reset),
        .dispatch_en(accept), .func(dispatch_func),
        .opa_preg(opa_preg), .opb_preg(opb_preg), .dest_preg(dest_preg),
        .opa_value(opa_value), .opb_value(opb_value),
        .opa_ready(opa_ready), .opb_ready(opb_ready),
        .opb_is_imm(dispatch_opb_is_imm), .imm(dispatch_imm), .rob_idx(rob_tail),
        .cdb(cdb_bus), .rs_full(rs_full),
        .issue_valid(issue_valid), .issue_func(issue_func),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_preg(issue_preg), .issue_rob_idx(issue_rob_idx)
    );

    alu_unit alu_unit_i (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue_func(issue_func),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_preg(issue_preg), .issue_rob_idx(issue_rob_idx),
        .cdb(cdb_bus)
    );

endmodule

// ==== test/ooo_core_tb.sv ====
// table driven testbench for ooo_core
// expected commits come from an architectural register model run in table order
// register state is assumed zero after reset, last table row is a halt
// the run ends once the halt commits or a wait runs out
`timescale 1ns/1ps

module ooo_core_tb import ooo_pkg::*; ();

    localparam int MAX_ROWS   = 64;
    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 200;    // cycles per dispatch handshake
    localparam int HALT_LIMIT = 2000;   // cycles for the halt to commit

    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    alu_func_t dispatch_func;
    areg_t     dispatch_dest_areg;
    areg_t     dispatch_opa_areg;
    areg_t     dispatch_opb_areg;
    logic      dispatch_opb_is_imm;
    word_t     dispatch_imm;
    logic      dispatch_halt;
    logic      dispatch_ready;
    logic      commit_valid;
    areg_t     commit_areg;
    word_t     commit_value;
    logic      commit_halt;

    // stimulus table, one row per instruction
    alu_func_t row_func   [MAX_ROWS];
    areg_t     row_dest   [MAX_ROWS];
    areg_t     row_opa    [MAX_ROWS];
    areg_t     row_opb    [MAX_ROWS];
    logic      row_is_imm [MAX_ROWS];
    word_t     row_imm    [MAX_ROWS];
    logic      row_halt   [MAX_ROWS];
    int        row_gap    [MAX_ROWS];   // idle cycles before the row
    int        row_test   [MAX_ROWS];
    word_t     exp_value  [MAX_ROWS];
    int        row_count;
    int        commit_idx;              // next row expected to commit
    int        checks;
    int        errors;
    int        burst_stalls;
    int        test_errors   [NUM_TESTS+1];
    int        test_last_row [NUM_TESTS+1];
    string     test_name     [NUM_TESTS+1];
    logic      halt_seen;
    logic      timed_out;
    logic [31:0] lcg_state;

    ooo_core dut_i (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_func(dispatch_func),
        .dispatch_dest_areg(dispatch_dest_areg), .dispatch_opa_areg(dispatch_opa_areg),
        .dispatch_opb_areg(dispatch_opb_areg), .dispatch_opb_is_imm(dispatch_opb_is_imm),
        .dispatch_imm(dispatch_imm), .dispatch_halt(dispatch_halt),
        .dispatch_ready(dispatch_ready), .commit_valid(commit_valid),
        .commit_areg(commit_areg), .commit_value(commit_value), .commit_halt(commit_halt)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;     // 40 ns period
    end

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // integer ops by the RISC-V rules
    function automatic word_t model_alu(input alu_func_t f, input word_t a, input word_t b);
        logic [4:0]  sh;
        logic [63:0] ext;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;   // sign filled from the left
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return ext[31:0];
            ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: return {31'b0, a < b};
            default:  return '0;
        endcase
    endfunction

    task automatic add_row(input int t, input alu_func_t f, input areg_t d, input areg_t a,
                           input areg_t b, input logic is_imm, input word_t imm, input int gap);
        row_func[row_count]   = f;
        row_dest[row_count]   = d;
        row_opa[row_count]    = a;
        row_opb[row_count]    = b;
        row_is_imm[row_count] = is_imm;
        row_imm[row_count]    = imm;
        row_halt[row_count]   = 1'b0;
        row_gap[row_count]    = gap;
        row_test[row_count]   = t;
        test_last_row[t]      = row_count;
        row_count++;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        areg_t       dest;
        areg_t       prev;
        row_count = 0;
        for (int t = 0; t <= NUM_TESTS; t++) begin
            test_errors[t]   = 0;
            test_last_row[t] = -1;
        end
        test_name[1] = "reset state";
        test_name[2] = "immediate ops";
        test_name[3] = "dependency chains";
        test_name[4] = "register zero";
        test_name[5] = "dependent burst";
        test_name[6] = "halt";
        // every function against one loaded value
        add_row(2, ALU_ADD,  5'd1,  5'd0, 5'd0, 1'b1, 32'h8000_00f3, 0);
        add_row(2, ALU_ADD,  5'd3,  5'd1, 5'd0, 1'b1, 32'h0000_0005, 1);
        add_row(2, ALU_SUB,  5'd4,  5'd1, 5'd0, 1'b1, 32'h0000_0100, 0);
        add_row(2, ALU_AND,  5'd5,  5'd1, 5'd0, 1'b1, 32'h0000_00ff, 0);
        add_row(2, ALU_OR,   5'd6,  5'd1, 5'd0, 1'b1, 32'h0000_0f00, 2);
        add_row(2, ALU_XOR,  5'd7,  5'd1, 5'd0, 1'b1, 32'hffff_ffff, 0);
        add_row(2, ALU_SLL,  5'd8,  5'd1, 5'd0, 1'b1, 32'h0000_0004, 0);
        add_row(2, ALU_SRL,  5'd9,  5'd1, 5'd0, 1'b1, 32'h0000_0023, 1);  // only low 5 bits count
        add_row(2, ALU_SRA,  5'd10, 5'd1, 5'd0, 1'b1, 32'h0000_0008, 0);
        add_row(2, ALU_SLT,  5'd11, 5'd1, 5'd0, 1'b1, 32'h0000_0001, 0);
        add_row(2, ALU_SLTU, 5'd12, 5'd1, 5'd0, 1'b1, 32'h0000_0001, 0);
        // register operands, one destination reused
        add_row(3, ALU_ADD, 5'd13, 5'd3, 5'd4, 1'b0, '0, 0);
        add_row(3, ALU_SUB, 5'd14, 5'd13, 5'd5, 1'b0, '0, 0);
        add_row(3, ALU_ADD, 5'd15, 5'd14, 5'd0, 1'b1, '0, 2);
        for (int i = 0; i < 8; i++)
            add_row(3, ALU_ADD, 5'd15, 5'd15, 5'd0, 1'b1, word_t'(i + 1), 0);
        add_row(3, ALU_XOR, 5'd15, 5'd15, 5'd13, 1'b0, '0, 0);
        add_row(3, ALU_SRA, 5'd16, 5'd15, 5'd8, 1'b0, '0, 1);
        // x0 as destination and source
        add_row(4, ALU_ADD, 5'd0,  5'd1, 5'd0, 1'b1, 32'h0000_0007, 0);
        add_row(4, ALU_ADD, 5'd17, 5'd0, 5'd0, 1'b0, '0, 0);
        add_row(4, ALU_OR,  5'd18, 5'd0, 5'd0, 1'b1, 32'h0000_0055, 0);
        add_row(4, ALU_SUB, 5'd19, 5'd1, 5'd0, 1'b0, '0, 3);
        // random chain, each op reads the one before
        prev = 5'd15;
        for (int k = 0; k < 24; k++) begin
            rnd  = lcg_next();
            dest = areg_t'(rnd[18:16] % 3'd7) + 5'd1;
            add_row(5, alu_func_t'(rnd[23:20] % 4'd10), dest, prev, {2'b0, rnd[26:24]},
                    rnd[27], lcg_next(), 0);
            prev = dest;
        end
        add_row(6, ALU_ADD, 5'd0, 5'd0, 5'd0, 1'b0, '0, 1);
        row_halt[row_count-1] = 1'b1;
    endtask

    task automatic predict_commits();
        word_t arch [AREG_COUNT];
        word_t b;
        for (int i = 0; i < AREG_COUNT; i++)
            arch[i] = '0;
        for (int r = 0; r < row_count; r++) begin
            if (row_halt[r]) begin
                exp_value[r] = '0;
            end else begin
                b = row_is_imm[r] ? row_imm[r] : arch[row_opb[r]];
                exp_value[r] = (row_dest[r] == ZERO_REG) ? '0
                             : model_alu(row_func[r], arch[row_opa[r]], b);
                if (row_dest[r] != ZERO_REG)
                    arch[row_dest[r]] = exp_value[r];
            end
        end
    endtask

    task automatic check_word(input int t, input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
            test_errors[t]++;
        end
    endtask

    task automatic finish_test(input int t);
        string verdict;
        if (t == 5) begin
            checks++;
            if (burst_stalls == 0) begin
                $display("burst never saw dispatch_ready low");
                errors++;
                test_errors[t]++;
            end
        end
        if (test_errors[t] == 0)
            verdict = "ok";
        else
            verdict = "failed";
        $display("test %0d %s: %s, %0d errors", t, test_name[t], verdict, test_errors[t]);
    endtask

    ////////////////////////////////////////
    // commit monitor, sampled mid cycle
    ////////////////////////////////////////
    task automatic check_commit(input int r);
        int t;
        t = row_test[r];
        check_word(t, "commit_halt", {31'b0, commit_halt}, {31'b0, row_halt[r]});
        if (!row_halt[r]) begin
            check_word(t, "commit_areg", {27'b0, commit_areg}, {27'b0, row_dest[r]});
            check_word(t, "commit_value", commit_value, exp_value[r]);
        end else begin
            halt_seen = 1'b1;
        end
        if (r == test_last_row[t])
            finish_test(t);
    endtask

    always @(negedge clock) begin
        if (!reset && commit_valid === 1'b1) begin
            if (commit_idx >= row_count) begin
                $display("extra commit at %0t ns after the program ended", $time);
                errors++;
            end else begin
                check_commit(commit_idx);
                commit_idx++;
            end
        end
    end

    // called just after a rising edge, returns on the edge that takes the row
    task automatic send_row(input int r);
        int   waited;
        logic ready_seen;
        if (row_gap[r] > 0) begin
            dispatch_valid <= 1'b0;
            repeat (row_gap[r]) @(posedge clock);
        end
        dispatch_valid      <= 1'b1;
        dispatch_func       <= row_func[r];
        dispatch_dest_areg  <= row_dest[r];
        dispatch_opa_areg   <= row_opa[r];
        dispatch_opb_areg   <= row_opb[r];
        dispatch_opb_is_imm <= row_is_imm[r];
        dispatch_imm        <= row_imm[r];
        dispatch_halt       <= row_halt[r];
        waited     = 0;
        ready_seen = 1'b0;
        while (!ready_seen && waited < WAIT_LIMIT) begin
            @(negedge clock);
            ready_seen = dispatch_ready;     // stable until the next edge
            @(posedge clock);
            if (!ready_seen && row_test[r] == 5)
                burst_stalls++;
            waited++;
        end
        if (!ready_seen) begin
            $display("timeout: row %0d was never taken, dispatch_ready stayed low", r);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int waited;
        reset               = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_func       = ALU_ADD;
        dispatch_dest_areg  = '0;
        dispatch_opa_areg   = '0;
        dispatch_opb_areg   = '0;
        dispatch_opb_is_imm = 1'b0;
        dispatch_imm        = '0;
        dispatch_halt       = 1'b0;
        commit_idx   = 0;
        checks       = 0;
        errors       = 0;
        burst_stalls = 0;
        halt_seen    = 1'b0;
        timed_out    = 1'b0;
        lcg_state    = 32'he611_f6be;
        build_table();
        predict_commits();
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_word(1, "commit_valid", {31'b0, commit_valid}, 32'd0);
        check_word(1, "commit_halt", {31'b0, commit_halt}, 32'd0);
        check_word(1, "dispatch_ready", {31'b0, dispatch_ready}, 32'd1);
        finish_test(1);
        @(posedge clock);
        for (int r = 0; r < row_count && !timed_out; r++)
            send_row(r);
        dispatch_valid <= 1'b0;
        dispatch_halt  <= 1'b0;
        waited = 0;
        while (!halt_seen && !timed_out && waited < HALT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (!halt_seen && !timed_out) begin
            $display("timeout: the halt never committed");
            timed_out = 1'b1;
            errors++;
        end
        repeat (4) @(posedge clock);    // room for stray commits
        if (commit_idx != row_count) begin
            $display("only %0d of %0d instructions committed", commit_idx, row_count);
            errors++;
        end
        $display("checks %0d, errors %0d, burst stall cycles %0d", checks, errors, burst_stalls);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== ooo_core.f ====
logic/ooo_pkg.sv
logic/cdb_if.sv
logic/rename_map.sv
logic/phys_reg_file.sv
logic/reorder_buffer.sv
logic/alu_station.sv
logic/alu_unit.sv
logic/ooo_core.sv
test/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ooo_core testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f ooo_core.f --top-module ooo_core_tb -o ooo_core_sim
./obj_dir/ooo_core_sim > sim.log 2>&1
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
